// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= core_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/arch_reg_file.sv
`timescale 1ns/1ns

module arch_reg_file (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [core_pkg::AREG_W-1:0] rd_addr1,
	input  logic [core_pkg::AREG_W-1:0] rd_addr2,
	input  logic                        wr_vld,
	input  logic [core_pkg::AREG_W-1:0] wr_addr,
	input  logic [core_pkg::DATA_W-1:0] wr_data,
	output logic [core_pkg::DATA_W-1:0] rd_data1,
	output logic [core_pkg::DATA_W-1:0] rd_data2
);
	import core_pkg::*;

	logic [DATA_W-1:0] regs [NUM_AREGS];

	// committed state only
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_AREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_vld) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

// File: logic/core_pkg.sv
package core_pkg;

	// register values and architectural register numbers
	localparam int DATA_W = 16;
	localparam int AREG_W = 4;
	localparam int NUM_AREGS = 16;

	// reorder buffer, depth is a power of two so the pointers wrap on their own
	localparam int ROB_DEPTH = 4;
	localparam int ROB_IDX_W = 2;

	// multiplier pipeline depth
	localparam int MULT_STAGES = 3;

	// all results wrap modulo 2^16
	typedef enum logic [2:0] {
		// a + b
		OP_ADD = 3'd0,
		// a - b
		OP_SUB = 3'd1,
		// a & b
		OP_AND = 3'd2,
		// a | b
		OP_OR  = 3'd3,
		// a ^ b
		OP_XOR = 3'd4,
		// a << b[3:0]
		OP_SHL = 3'd5,
		// immediate, sources ignored
		OP_LDI = 3'd6,
		// low half of a * b, goes to the multiplier
		OP_MUL = 3'd7
	} opcode_t;

endpackage

// File: logic/core_top.sv
`timescale 1ns/1ns

module core_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        issue_vld,
	input  core_pkg::opcode_t           issue_op,
	input  logic [core_pkg::AREG_W-1:0] issue_rd,
	input  logic [core_pkg::AREG_W-1:0] issue_rs1,
	input  logic [core_pkg::AREG_W-1:0] issue_rs2,
	input  logic [core_pkg::DATA_W-1:0] issue_imm,
	output logic                        issue_stall,
	output logic                        cmt_vld,
	output logic [core_pkg::AREG_W-1:0] cmt_rd,
	output logic [core_pkg::DATA_W-1:0] cmt_data
);
	import core_pkg::*;

	// issue to reorder buffer
	logic                 rob_full;
	logic [ROB_IDX_W-1:0] rob_tail;
	logic                 alloc_vld;
	logic [AREG_W-1:0]    alloc_rd;

	// register file reads
	logic [AREG_W-1:0]    rd_addr1;
	logic [AREG_W-1:0]    rd_addr2;
	logic [DATA_W-1:0]    rd_data1;
	logic [DATA_W-1:0]    rd_data2;

	// dispatch
	logic                 disp_vld;
	opcode_t              disp_op;
	logic [DATA_W-1:0]    disp_a;
	logic [DATA_W-1:0]    disp_b;
	logic [DATA_W-1:0]    disp_imm;
	logic [ROB_IDX_W-1:0] disp_tag;

	// completion
	logic                 alu_done;
	logic [ROB_IDX_W-1:0] alu_tag;
	logic [DATA_W-1:0]    alu_data;
	logic                 mul_done;
	logic [ROB_IDX_W-1:0] mul_tag;
	logic [DATA_W-1:0]    mul_data;

	issue_stage issue0 (
		.clk(clk), .rst(rst),
		.issue_vld(issue_vld), .issue_op(issue_op), .issue_rd(issue_rd),
		.issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
		.rob_full(rob_full), .rob_tail(rob_tail),
		.rd_data1(rd_data1), .rd_data2(rd_data2),
		.cmt_vld(cmt_vld), .cmt_rd(cmt_rd),
		.issue_stall(issue_stall), .alloc_vld(alloc_vld), .alloc_rd(alloc_rd),
		.rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.disp_vld(disp_vld), .disp_op(disp_op), .disp_a(disp_a), .disp_b(disp_b),
		.disp_imm(disp_imm), .disp_tag(disp_tag)
	);

	exec_stage exec0 (
		.clk(clk), .rst(rst),
		.disp_vld(disp_vld), .disp_op(disp_op), .disp_a(disp_a), .disp_b(disp_b),
		.disp_imm(disp_imm), .disp_tag(disp_tag),
		.alu_done(alu_done), .alu_tag(alu_tag), .alu_data(alu_data),
		.mul_done(mul_done), .mul_tag(mul_tag), .mul_data(mul_data)
	);

	reorder_buffer rob0 (
		.clk(clk), .rst(rst),
		.alloc_vld(alloc_vld), .alloc_rd(alloc_rd),
		.alu_done(alu_done), .alu_tag(alu_tag), .alu_data(alu_data),
		.mul_done(mul_done), .mul_tag(mul_tag), .mul_data(mul_data),
		.rob_tail(rob_tail), .rob_full(rob_full),
		.cmt_vld(cmt_vld), .cmt_rd(cmt_rd), .cmt_data(cmt_data)
	);

	// commit is the only writer of architectural state
	arch_reg_file arf0 (
		.clk(clk), .rst(rst),
		.rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.wr_vld(cmt_vld), .wr_addr(cmt_rd), .wr_data(cmt_data),
		.rd_data1(rd_data1), .rd_data2(rd_data2)
	);

endmodule

// File: logic/exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           disp_vld,
	input  core_pkg::opcode_t              disp_op,
	input  logic [core_pkg::DATA_W-1:0]    disp_a,
	input  logic [core_pkg::DATA_W-1:0]    disp_b,
	input  logic [core_pkg::DATA_W-1:0]    disp_imm,
	input  logic [core_pkg::ROB_IDX_W-1:0] disp_tag,
	output logic                           alu_done,
	output logic [core_pkg::ROB_IDX_W-1:0] alu_tag,
	output logic [core_pkg::DATA_W-1:0]    alu_data,
	output logic                           mul_done,
	output logic [core_pkg::ROB_IDX_W-1:0] mul_tag,
	output logic [core_pkg::DATA_W-1:0]    mul_data
);
	import core_pkg::*;

	logic              is_mul;
	logic [DATA_W-1:0] alu_res;

	assign is_mul = (disp_op == OP_MUL);

	always_comb begin
		case (disp_op)
			OP_ADD:  alu_res = disp_a + disp_b;
			OP_SUB:  alu_res = disp_a - disp_b;
			OP_AND:  alu_res = disp_a & disp_b;
			OP_OR:   alu_res = disp_a | disp_b;
			OP_XOR:  alu_res = disp_a ^ disp_b;
			// shift amount is the low nibble only
			OP_SHL:  alu_res = disp_a << disp_b[3:0];
			OP_LDI:  alu_res = disp_imm;
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			alu_done <= 1'b0;
		end else begin
			alu_done <= disp_vld & ~is_mul;
		end
	end

	always_ff @(posedge clk) begin
		alu_tag <= disp_tag;
		alu_data <= alu_res;
	end

	mult_unit mult0 (
		.clk      (clk),
		.rst      (rst),
		.in_vld   (disp_vld & is_mul),
		.in_a     (disp_a),
		.in_b     (disp_b),
		.in_tag   (disp_tag),
		.out_vld  (mul_done),
		.out_tag  (mul_tag),
		.out_data (mul_data)
	);

endmodule

// File: logic/issue_stage.sv
`timescale 1ns/1ns

module issue_stage (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         issue_vld,
	input  core_pkg::opcode_t            issue_op,
	input  logic [core_pkg::AREG_W-1:0]  issue_rd,
	input  logic [core_pkg::AREG_W-1:0]  issue_rs1,
	input  logic [core_pkg::AREG_W-1:0]  issue_rs2,
	input  logic [core_pkg::DATA_W-1:0]  issue_imm,
	input  logic                         rob_full,
	input  logic [core_pkg::ROB_IDX_W-1:0] rob_tail,
	input  logic [core_pkg::DATA_W-1:0]  rd_data1,
	input  logic [core_pkg::DATA_W-1:0]  rd_data2,
	input  logic                         cmt_vld,
	input  logic [core_pkg::AREG_W-1:0]  cmt_rd,
	output logic                         issue_stall,
	output logic                         alloc_vld,
	output logic [core_pkg::AREG_W-1:0]  alloc_rd,
	output logic [core_pkg::AREG_W-1:0]  rd_addr1,
	output logic [core_pkg::AREG_W-1:0]  rd_addr2,
	output logic                         disp_vld,
	output core_pkg::opcode_t            disp_op,
	output logic [core_pkg::DATA_W-1:0]  disp_a,
	output logic [core_pkg::DATA_W-1:0]  disp_b,
	output logic [core_pkg::DATA_W-1:0]  disp_imm,
	output logic [core_pkg::ROB_IDX_W-1:0] disp_tag
);
	import core_pkg::*;

	// one bit per register with a write still in flight
	logic [NUM_AREGS-1:0] pending;
	logic                 src_busy;
	logic                 accept;

	// ldi reads no sources, so only its destination matters
	assign src_busy = (pending[issue_rs1] | pending[issue_rs2]) & (issue_op != OP_LDI);
	assign issue_stall = rob_full | pending[issue_rd] | src_busy;
	assign accept = issue_vld & ~issue_stall;

	assign alloc_vld = accept;
	assign alloc_rd = issue_rd;

	// operands come straight from the architectural file
	assign rd_addr1 = issue_rs1;
	assign rd_addr2 = issue_rs2;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			if (cmt_vld) begin
				pending[cmt_rd] <= 1'b0;
			end
			// a stalled rd cannot be the one committing, set wins anyway
			if (accept) begin
				pending[issue_rd] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			disp_vld <= 1'b0;
		end else begin
			disp_vld <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			disp_op <= issue_op;
			disp_a <= rd_data1;
			disp_b <= rd_data2;
			disp_imm <= issue_imm;
			disp_tag <= rob_tail;
		end
	end

endmodule

// File: logic/mult_unit.sv
`timescale 1ns/1ns

module mult_unit (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           in_vld,
	input  logic [core_pkg::DATA_W-1:0]    in_a,
	input  logic [core_pkg::DATA_W-1:0]    in_b,
	input  logic [core_pkg::ROB_IDX_W-1:0] in_tag,
	output logic                           out_vld,
	output logic [core_pkg::ROB_IDX_W-1:0] out_tag,
	output logic [core_pkg::DATA_W-1:0]    out_data
);
	import core_pkg::*;

	logic [MULT_STAGES-1:0] vld_q;
	logic [ROB_IDX_W-1:0]   tag_q [MULT_STAGES];
	logic [DATA_W-1:0]      prod_q [MULT_STAGES];
	// operand a and the upper half of b wait one stage for the second partial product
	logic [DATA_W-1:0]      a_q;
	logic [DATA_W/2-1:0]    bh_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[MULT_STAGES-2:0], in_vld};
		end
	end

	always_ff @(posedge clk) begin
		a_q <= in_a;
		bh_q <= in_b[DATA_W-1:DATA_W/2];
		tag_q[0] <= in_tag;
		// low half of b first
		prod_q[0] <= in_a * DATA_W'(in_b[DATA_W/2-1:0]);
		tag_q[1] <= tag_q[0];
		prod_q[1] <= prod_q[0] + ((a_q * DATA_W'(bh_q)) << (DATA_W / 2));
		for (int i = 2; i < MULT_STAGES; i++) begin
			tag_q[i] <= tag_q[i-1];
			prod_q[i] <= prod_q[i-1];
		end
	end

	assign out_vld = vld_q[MULT_STAGES-1];
	assign out_tag = tag_q[MULT_STAGES-1];
	assign out_data = prod_q[MULT_STAGES-1];

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           alloc_vld,
	input  logic [core_pkg::AREG_W-1:0]    alloc_rd,
	input  logic                           alu_done,
	input  logic [core_pkg::ROB_IDX_W-1:0] alu_tag,
	input  logic [core_pkg::DATA_W-1:0]    alu_data,
	input  logic                           mul_done,
	input  logic [core_pkg::ROB_IDX_W-1:0] mul_tag,
	input  logic [core_pkg::DATA_W-1:0]    mul_data,
	output logic [core_pkg::ROB_IDX_W-1:0] rob_tail,
	output logic                           rob_full,
	output logic                           cmt_vld,
	output logic [core_pkg::AREG_W-1:0]    cmt_rd,
	output logic [core_pkg::DATA_W-1:0]    cmt_data
);
	import core_pkg::*;

	logic [ROB_IDX_W-1:0] head;
	logic [ROB_IDX_W-1:0] tail;
	logic [ROB_IDX_W:0]   count;
	logic [ROB_DEPTH-1:0] busy;
	logic [ROB_DEPTH-1:0] done;
	logic [AREG_W-1:0]    rd_q [ROB_DEPTH];
	logic [DATA_W-1:0]    value_q [ROB_DEPTH];

	assign rob_tail = tail;
	assign rob_full = (count == (ROB_IDX_W + 1)'(ROB_DEPTH));

	// the oldest entry commits once its done bit is set
	assign cmt_vld = busy[head] && done[head];
	assign cmt_rd = rd_q[head];
	assign cmt_data = value_q[head];

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			busy <= '0;
			done <= '0;
		end else begin
			if (alu_done) begin
				done[alu_tag] <= 1'b1;
			end
			if (mul_done) begin
				done[mul_tag] <= 1'b1;
			end
			if (alloc_vld) begin
				busy[tail] <= 1'b1;
				done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			// free the head entry on commit
			if (cmt_vld) begin
				busy[head] <= 1'b0;
				done[head] <= 1'b0;
				head <= head + 1'b1;
			end
			case ({alloc_vld, cmt_vld})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (alloc_vld) begin
			rd_q[tail] <= alloc_rd;
		end
		if (alu_done) begin
			value_q[alu_tag] <= alu_data;
		end
		if (mul_done) begin
			value_q[mul_tag] <= mul_data;
		end
	end

endmodule

// File: sim.f
logic/core_pkg.sv
logic/mult_unit.sv
logic/exec_stage.sv
logic/issue_stage.sv
logic/reorder_buffer.sv
logic/arch_reg_file.sv
logic/core_top.sv
test/core_assertions.sv
test/core_tb.sv

// File: test/core_assertions.sv
`timescale 1ns/1ns

module core_assertions (
	input logic                        clk,
	input logic                        rst,
	input logic                        issue_vld,
	input core_pkg::opcode_t           issue_op,
	input logic [core_pkg::AREG_W-1:0] issue_rd,
	input logic [core_pkg::AREG_W-1:0] issue_rs1,
	input logic [core_pkg::AREG_W-1:0] issue_rs2,
	input logic                        issue_stall,
	input logic                        cmt_vld,
	input logic [core_pkg::AREG_W-1:0] cmt_rd
);
	import core_pkg::*;

	// registers with a write accepted but not yet committed
	logic [NUM_AREGS-1:0] pend;
	int                   outstanding;
	logic                 started = 1'b0;
	int                   fail_cnt = 0;
	logic                 accept;
	logic                 conflict;

	assign accept = issue_vld && !issue_stall;
	assign conflict = pend[issue_rd] ||
		((issue_op != OP_LDI) && (pend[issue_rs1] || pend[issue_rs2]));

	always_ff @(posedge clk) begin
		started <= 1'b1;
		if (rst) begin
			pend <= '0;
			outstanding <= 0;
		end else begin
			if (cmt_vld) begin
				pend[cmt_rd] <= 1'b0;
			end
			if (accept) begin
				pend[issue_rd] <= 1'b1;
			end
			outstanding <= outstanding + (accept ? 1 : 0) - (cmt_vld ? 1 : 0);
		end
	end

	a_reset_quiet: assert property (@(posedge clk)
		(started && (rst || $past(rst))) |-> (!cmt_vld && !issue_stall))
		else begin $error("commit or stall active around reset"); fail_cnt++; end

	a_scoreboard: assert property (@(posedge clk) disable iff (rst)
		(issue_vld && conflict) |-> issue_stall)
		else begin $error("register conflict not stalled"); fail_cnt++; end

	// without a conflict only a full reorder buffer may stall
	a_stall_reason: assert property (@(posedge clk) disable iff (rst)
		(issue_vld && issue_stall && !conflict) |-> (outstanding == ROB_DEPTH))
		else begin $error("stall without conflict or full buffer"); fail_cnt++; end

	a_rob_bound: assert property (@(posedge clk) disable iff (rst)
		outstanding <= ROB_DEPTH)
		else begin $error("too many instructions in flight"); fail_cnt++; end

	a_full_stall: assert property (@(posedge clk) disable iff (rst)
		(outstanding == ROB_DEPTH) |-> issue_stall)
		else begin $error("full reorder buffer not stalled"); fail_cnt++; end

endmodule

bind core_top core_assertions chk0 (
	.clk(clk), .rst(rst), .issue_vld(issue_vld), .issue_op(issue_op),
	.issue_rd(issue_rd), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
	.issue_stall(issue_stall), .cmt_vld(cmt_vld), .cmt_rd(cmt_rd)
);

// File: test/core_tb.sv
`timescale 1ns/1ns

module core_tb;
	import core_pkg::*;

	localparam int HALF = 10;
	localparam int TIMEOUT = 200;
	localparam int NUM_RANDOM = 300;

	logic              clk;
	logic              rst;
	logic              issue_vld;
	opcode_t           issue_op;
	logic [AREG_W-1:0] issue_rd;
	logic [AREG_W-1:0] issue_rs1;
	logic [AREG_W-1:0] issue_rs2;
	logic [DATA_W-1:0] issue_imm;
	logic              issue_stall;
	logic              cmt_vld;
	logic [AREG_W-1:0] cmt_rd;
	logic [DATA_W-1:0] cmt_data;

	int          err_cnt = 0;
	int          cyc = 0;
	int          cmt_cnt = 0;
	int          last_cmt_cyc = 0;
	int          last_acc_cyc = 0;
	bit          timed_out = 0;
	logic [31:0] rng = 32'h081f_2a9e;

	// committed state as the program order implies it
	logic [DATA_W-1:0] ref_regs [NUM_AREGS];
	logic [AREG_W-1:0] exp_rd_q [$];
	logic [DATA_W-1:0] exp_data_q [$];

	core_top dut0 (
		.clk(clk), .rst(rst), .issue_vld(issue_vld), .issue_op(issue_op),
		.issue_rd(issue_rd), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
		.issue_imm(issue_imm), .issue_stall(issue_stall),
		.cmt_vld(cmt_vld), .cmt_rd(cmt_rd), .cmt_data(cmt_data)
	);

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [DATA_W-1:0] calc_result(input opcode_t op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
		input logic [DATA_W-1:0] imm);
		logic [2*DATA_W-1:0] prod;
		prod = a * b;
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SHL:  return a << b[3:0];
			OP_LDI:  return imm;
			default: return prod[DATA_W-1:0];
		endcase
	endfunction

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic issue_one(input opcode_t op, input logic [AREG_W-1:0] rd,
		input logic [AREG_W-1:0] rs1, input logic [AREG_W-1:0] rs2,
		input logic [DATA_W-1:0] imm);
		int t;
		bit accepted;
		logic [DATA_W-1:0] res;
		if (timed_out) return;
		issue_vld = 1'b1;
		issue_op = op;
		issue_rd = rd;
		issue_rs1 = rs1;
		issue_rs2 = rs2;
		issue_imm = imm;
		accepted = 0;
		for (t = 0; t < TIMEOUT && !accepted; t++) begin
			// look just before the rising edge
			#(HALF - 1);
			if (!issue_stall) begin
				accepted = 1;
				last_acc_cyc = cyc + 1;
				res = calc_result(op, ref_regs[rs1], ref_regs[rs2], imm);
				ref_regs[rd] = res;
				exp_rd_q.push_back(rd);
				exp_data_q.push_back(res);
			end
			@(negedge clk);
		end
		issue_vld = 1'b0;
		if (!accepted) begin
			$display("timeout at %0t: instruction was never accepted", $time);
			timed_out = 1;
		end
	endtask

	task automatic wait_drain;
		int t;
		if (timed_out) return;
		for (t = 0; t < TIMEOUT && exp_rd_q.size() != 0; t++) begin
			@(negedge clk);
		end
		if (exp_rd_q.size() != 0) begin
			$display("timeout at %0t: pipeline did not drain", $time);
			timed_out = 1;
		end
	endtask

	task automatic check_latency(input opcode_t op, input logic [AREG_W-1:0] rd,
		input int lat);
		int t;
		int start;
		bit seen;
		wait_drain();
		if (timed_out) return;
		start = cmt_cnt;
		issue_one(op, rd, 4'd1, 4'd2, 16'h1234);
		seen = 0;
		for (t = 0; t < TIMEOUT && !seen && !timed_out; t++) begin
			#1;
			if (cmt_cnt != start) begin
				seen = 1;
			end
			@(negedge clk);
		end
		if (timed_out) return;
		if (!seen) begin
			$display("timeout at %0t: fixed-latency instruction never committed", $time);
			timed_out = 1;
		end else if (last_cmt_cyc - last_acc_cyc != lat) begin
			$display("ERR %0t commit_latency expected %0d got %0d", $time, lat,
				last_cmt_cyc - last_acc_cyc);
			err_cnt++;
		end
	endtask

	// commit checker, outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst && cmt_vld) begin
			if (exp_rd_q.size() == 0) begin
				$display("commit at %0t with no instruction outstanding", $time);
				err_cnt++;
			end else begin
				if (cmt_rd !== exp_rd_q[0]) begin
					$display("ERR %0t cmt_rd expected %0h got %0h", $time,
						exp_rd_q[0], cmt_rd);
					err_cnt++;
				end
				if (cmt_data !== exp_data_q[0]) begin
					$display("ERR %0t cmt_data expected %0h got %0h", $time,
						exp_data_q[0], cmt_data);
					err_cnt++;
				end
				void'(exp_rd_q.pop_front());
				void'(exp_data_q.pop_front());
			end
			cmt_cnt++;
			last_cmt_cyc = cyc;
		end
	end

	initial begin
		rst = 1'b1;
		issue_vld = 1'b0;
		issue_op = OP_ADD;
		issue_rd = '0;
		issue_rs1 = '0;
		issue_rs2 = '0;
		issue_imm = '0;
		for (int i = 0; i < NUM_AREGS; i++) begin
			ref_regs[i] = '0;
		end
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// seed some values, then check latency in an empty machine
		issue_one(OP_LDI, 4'd1, 4'd0, 4'd0, 16'h00a5);
		issue_one(OP_LDI, 4'd2, 4'd0, 4'd0, 16'h0103);
		check_latency(OP_ADD, 4'd3, 2);
		check_latency(OP_MUL, 4'd4, 4);
		check_latency(OP_LDI, 4'd5, 2);

		// multiply overtaken by younger independent ALU work
		wait_drain();
		issue_one(OP_MUL, 4'd6, 4'd1, 4'd2, 16'h0000);
		issue_one(OP_ADD, 4'd7, 4'd1, 4'd2, 16'h0000);
		issue_one(OP_XOR, 4'd8, 4'd1, 4'd5, 16'h0000);
		issue_one(OP_SHL, 4'd9, 4'd2, 4'd1, 16'h0000);

		// one slow multiply then loads until the buffer fills
		wait_drain();
		issue_one(OP_MUL, 4'd10, 4'd1, 4'd1, 16'h0000);
		issue_one(OP_LDI, 4'd11, 4'd10, 4'd10, 16'hbeef);
		issue_one(OP_LDI, 4'd12, 4'd0, 4'd0, 16'h7001);
		issue_one(OP_LDI, 4'd13, 4'd0, 4'd0, 16'h8002);
		issue_one(OP_LDI, 4'd14, 4'd0, 4'd0, 16'h9003);

		for (int n = 0; n < NUM_RANDOM; n++) begin
			rng = xorshift(rng);
			issue_one(opcode_t'(rng[2:0]), rng[6:3], rng[10:7], rng[14:11],
				rng[31:16]);
		end
		wait_drain();
		repeat (4) @(negedge clk);

		$display("closing: %0d data errors, %0d assertion errors, timeout %0d",
			err_cnt, dut0.chk0.fail_cnt, timed_out);
		if (err_cnt == 0 && dut0.chk0.fail_cnt == 0 && !timed_out) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
